// File: source/rv32i_types.sv
package rv32i_types;

    localparam logic [6:0] br_opcode = 7'b1100011; // Conditional branch.

    typedef enum logic [2:0] {
        lb_mem,
        lbu_mem,
        lh_mem,
        lhu_mem,
        lw_mem
    } load_ops_t;

    // Source of the value written to rd.
    typedef enum logic [3:0] {
        alu_out_wb,
        br_en_wb,
        u_imm_wb,
        lw_wb,
        lb_wb,
        lbu_wb,
        lh_wb,
        lhu_wb,
        pc_plus4_wb
    } regf_m_sel_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        load_ops_t  load_ops;
    } mem_signal_t;

    typedef struct packed {
        logic        regf_we;
        regf_m_sel_t regf_m_sel;
    } wb_signal_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        mem_signal_t mem_signal;
        wb_signal_t  wb_signal;
        logic [31:0] alu_out;   // Also the data address.
        logic [31:0] br_en;
        logic [31:0] u_imm;
        logic [4:0]  rd_s;
        logic [31:0] rs2_v;     // Store data, already in its lanes.
        logic [3:0]  mem_wmask;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        mem_signal_t mem_signal;
        wb_signal_t  wb_signal;
        logic [31:0] alu_out;
        logic [31:0] br_en;
        logic [31:0] u_imm;
        logic [4:0]  rd_s;
        logic [31:0] mem_addr;
        logic [31:0] dmem_rdata; // Full response word.
    } mem_wb_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd_s;
        logic [31:0] rd_v;
        logic        regf_we;
    } commit_t;

endpackage

// File: source/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int mem_words = 256;
    localparam int mem_addr_bits = $clog2(mem_words);

    // One access on the shared memory. addr is a word address.
    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [3:0]               wmask;
        logic [mem_addr_bits-1:0] addr;
        logic [31:0]              wdata;
    } mem_req_t;

    typedef struct packed {
        logic        resp;   // One-cycle pulse.
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_types::ex_mem_t ex_mem,
    input  mem_bus_pkg::mem_rsp_t dmem_rsp,
    output mem_bus_pkg::mem_req_t dmem_req,
    output logic                 stall,
    output rv32i_types::mem_wb_t mem_wb
);

    logic mem_op;

    // Hold the record upstream until the response shows up.
    always_comb begin
        mem_op = ex_mem.valid &&
                 (ex_mem.mem_signal.mem_read || ex_mem.mem_signal.mem_write);
        stall = mem_op && !dmem_rsp.resp;
    end

    always_comb begin
        dmem_req.req   = mem_op;
        dmem_req.we    = ex_mem.mem_signal.mem_write;
        dmem_req.wmask = ex_mem.mem_signal.mem_write ? ex_mem.mem_wmask : 4'b0000;
        dmem_req.addr  = ex_mem.alu_out[2 +: mem_bus_pkg::mem_addr_bits];
        dmem_req.wdata = ex_mem.rs2_v;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid && !stall; // Bubble while waiting.
        end
        if (!stall) begin
            mem_wb.inst       <= ex_mem.inst;
            mem_wb.pc         <= ex_mem.pc;
            mem_wb.mem_signal <= ex_mem.mem_signal;
            mem_wb.wb_signal  <= ex_mem.wb_signal;
            mem_wb.alu_out    <= ex_mem.alu_out;
            mem_wb.br_en      <= ex_mem.br_en;
            mem_wb.u_imm      <= ex_mem.u_imm;
            mem_wb.rd_s       <= ex_mem.rd_s;
            mem_wb.mem_addr   <= ex_mem.alu_out;
            mem_wb.dmem_rdata <= dmem_rsp.rdata;
        end
    end

endmodule

// File: source/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  rv32i_types::mem_wb_t mem_wb,
    output rv32i_types::commit_t commit
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic [31:0] load_v;
    logic [31:0] rd_v;
    logic [4:0]  rd_s;

    // Lane picked by the low address bits.
    always_comb begin
        byte_lane = mem_wb.dmem_rdata[8 * mem_wb.mem_addr[1:0] +: 8];
        half_lane = mem_wb.dmem_rdata[16 * mem_wb.mem_addr[1] +: 16];
    end

    always_comb begin
        case (mem_wb.mem_signal.load_ops)
            rv32i_types::lb_mem:  load_v = {{24{byte_lane[7]}}, byte_lane};
            rv32i_types::lbu_mem: load_v = {24'd0, byte_lane};
            rv32i_types::lh_mem:  load_v = {{16{half_lane[15]}}, half_lane};
            rv32i_types::lhu_mem: load_v = {16'd0, half_lane};
            default:              load_v = mem_wb.dmem_rdata;
        endcase
    end

    always_comb begin
        case (mem_wb.wb_signal.regf_m_sel)
            rv32i_types::alu_out_wb:  rd_v = mem_wb.alu_out;
            rv32i_types::br_en_wb:    rd_v = mem_wb.br_en;
            rv32i_types::u_imm_wb:    rd_v = mem_wb.u_imm;
            rv32i_types::lw_wb,
            rv32i_types::lb_wb,
            rv32i_types::lbu_wb,
            rv32i_types::lh_wb,
            rv32i_types::lhu_wb:      rd_v = load_v;
            rv32i_types::pc_plus4_wb: rd_v = mem_wb.pc + 32'd4;
            default:                  rd_v = '0;
        endcase
    end

    // Stores and branches have no destination.
    always_comb begin
        rd_s = mem_wb.rd_s;
        if (mem_wb.mem_signal.mem_write) begin
            rd_s = '0;
        end
        if (mem_wb.inst[6:0] == rv32i_types::br_opcode) begin
            rd_s = '0;
        end
    end

    always_comb begin
        commit.valid   = mem_wb.valid;
        commit.rd_s    = rd_s;
        commit.rd_v    = rd_v;
        commit.regf_we = mem_wb.wb_signal.regf_we;
    end

endmodule

// File: source/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_types::commit_t commit,
    input  logic [4:0]           rs1_s,
    input  logic [4:0]           rs2_s,
    output logic [31:0]          rs1_v,
    output logic [31:0]          rs2_v
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.regf_we && (commit.rd_s != 5'd0)) begin
            regs[commit.rd_s] <= commit.rd_v;
        end
    end

    // No bypass of a same-cycle write.
    always_comb begin
        rs1_v = (rs1_s == 5'd0) ? 32'd0 : regs[rs1_s];
        rs2_v = (rs2_s == 5'd0) ? 32'd0 : regs[rs2_s];
    end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_en,
    input  logic [31:0]           fetch_start_pc,
    input  mem_bus_pkg::mem_rsp_t imem_rsp,
    output mem_bus_pkg::mem_req_t imem_req,
    output logic                  fetch_valid,
    output logic [31:0]           fetch_pc,
    output logic [31:0]           fetch_inst
);

    logic [31:0] pc;
    logic        pending;   // Request out, no response yet.

    always_comb begin
        imem_req.req   = pending;
        imem_req.we    = 1'b0;
        imem_req.wmask = 4'b0000;
        imem_req.addr  = pc[2 +: mem_bus_pkg::mem_addr_bits];
        imem_req.wdata = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= imem_rsp.resp;
            if (imem_rsp.resp) begin
                pending <= fetch_en; // Chain the next word.
            end else if (!pending) begin
                pending <= fetch_en;
            end
        end
        if (imem_rsp.resp) begin
            fetch_pc   <= pc;
            fetch_inst <= imem_rsp.rdata;
            pc         <= pc + 32'd4;
        end else if (!fetch_en && !pending) begin
            pc <= fetch_start_pc;
        end
    end

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::mem_req_t dmem_req,
    input  mem_bus_pkg::mem_req_t imem_req,
    input  mem_bus_pkg::mem_rsp_t mem_rsp,
    output mem_bus_pkg::mem_req_t mem_req,
    output mem_bus_pkg::mem_rsp_t dmem_rsp,
    output mem_bus_pkg::mem_rsp_t imem_rsp
);

    logic busy;      // Response due this cycle.
    logic owner_d;   // Data port owns the access in flight.
    logic grant_d;
    logic grant_i;

    always_comb begin
        grant_d = dmem_req.req && !busy;
        grant_i = imem_req.req && !dmem_req.req && !busy;
        mem_req = '0;
        if (grant_d) begin
            mem_req = dmem_req;
        end else if (grant_i) begin
            mem_req = imem_req;
        end
    end

    always_comb begin
        dmem_rsp.resp  = mem_rsp.resp && owner_d;
        dmem_rsp.rdata = mem_rsp.rdata;
        imem_rsp.resp  = mem_rsp.resp && !owner_d;
        imem_rsp.rdata = mem_rsp.rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
        end else begin
            busy <= grant_d || grant_i;
            if (grant_d || grant_i) begin
                owner_d <= grant_d;
            end
        end
    end

endmodule

// File: source/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::mem_req_t mem_req,
    output mem_bus_pkg::mem_rsp_t mem_rsp
);

    logic [31:0] mem [mem_bus_pkg::mem_words];

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rsp.resp <= 1'b0;
        end else begin
            mem_rsp.resp <= mem_req.req; // Every access answers next cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.req) begin
            mem_rsp.rdata <= mem[mem_req.addr]; // Old word on a write.
            if (mem_req.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem_req.wmask[i]) begin
                        mem[mem_req.addr][8*i +: 8] <= mem_req.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: source/backend_top.sv
`timescale 1ns/1ps

module backend_top (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_types::ex_mem_t ex_mem,
    input  logic                 fetch_en,
    input  logic [31:0]          fetch_start_pc,
    input  logic [4:0]           rs1_s,
    input  logic [4:0]           rs2_s,
    output logic                 stall,
    output rv32i_types::commit_t commit,
    output logic                 fetch_valid,
    output logic [31:0]          fetch_pc,
    output logic [31:0]          fetch_inst,
    output logic [31:0]          rs1_v,
    output logic [31:0]          rs2_v
);

    rv32i_types::mem_wb_t  mem_wb;
    mem_bus_pkg::mem_req_t dmem_req;
    mem_bus_pkg::mem_req_t imem_req;
    mem_bus_pkg::mem_req_t mem_req;
    mem_bus_pkg::mem_rsp_t dmem_rsp;
    mem_bus_pkg::mem_rsp_t imem_rsp;
    mem_bus_pkg::mem_rsp_t mem_rsp;

    mem_stage u_mem_stage (
        .clk(clk), .rst(rst), .ex_mem(ex_mem), .dmem_rsp(dmem_rsp),
        .dmem_req(dmem_req), .stall(stall), .mem_wb(mem_wb)
    );

    wb_stage u_wb_stage (.mem_wb(mem_wb), .commit(commit));

    regfile u_regfile (
        .clk(clk), .rst(rst), .commit(commit),
        .rs1_s(rs1_s), .rs2_s(rs2_s), .rs1_v(rs1_v), .rs2_v(rs2_v)
    );

    fetch_unit u_fetch_unit (
        .clk(clk), .rst(rst), .fetch_en(fetch_en), .fetch_start_pc(fetch_start_pc),
        .imem_rsp(imem_rsp), .imem_req(imem_req), .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc), .fetch_inst(fetch_inst)
    );

    // Data port wins over fetch.
    mem_arbiter u_mem_arbiter (
        .clk(clk), .rst(rst), .dmem_req(dmem_req), .imem_req(imem_req),
        .mem_rsp(mem_rsp), .mem_req(mem_req), .dmem_rsp(dmem_rsp), .imem_rsp(imem_rsp)
    );

    unified_mem u_unified_mem (.clk(clk), .rst(rst), .mem_req(mem_req), .mem_rsp(mem_rsp));

endmodule

// File: testbench/tb_backend.sv
`timescale 1ns/1ps

module tb_backend;

    localparam int fill_records   = mem_bus_pkg::mem_words;
    localparam int mix_records    = 100;
    localparam int fetch_records  = 30; // Keeps fetch inside the lower half.
    localparam int timeout_cycles = 3 * (fill_records + 16) +
                                    7 * (mix_records + fetch_records) + 200;

    logic                 clk = 1'b0;
    logic                 rst;
    rv32i_types::ex_mem_t ex_mem;
    logic                 fetch_en;
    logic [31:0]          fetch_start_pc;
    logic [4:0]           rs1_s;
    logic [4:0]           rs2_s;
    logic                 stall;
    rv32i_types::commit_t commit;
    logic                 fetch_valid;
    logic [31:0]          fetch_pc;
    logic [31:0]          fetch_inst;
    logic [31:0]          rs1_v;
    logic [31:0]          rs2_v;

    logic [31:0]          shadow_mem [mem_bus_pkg::mem_words];
    logic [31:0]          shadow_regs [32];
    rv32i_types::commit_t exp_q [$];
    logic                 checking = 1'b0;
    logic                 fetch_on = 1'b0;
    logic [31:0]          next_fetch_pc = 32'd0;
    int                   fetch_count = 0;

    backend_top dut_i (
        .clk(clk), .rst(rst), .ex_mem(ex_mem), .fetch_en(fetch_en),
        .fetch_start_pc(fetch_start_pc), .rs1_s(rs1_s), .rs2_s(rs2_s), .stall(stall),
        .commit(commit), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst), .rs1_v(rs1_v), .rs2_v(rs2_v)
    );

    always #2 clk = ~clk;

    // Read ports sweep all registers, x0 included.
    always @(posedge clk) begin
        rs1_s <= rs1_s + 5'd1;
        rs2_s <= rs2_s + 5'd3;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped.");
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] mask);
        logic [31:0] bits;
        bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (data & bits) | (old & ~bits);
    endfunction

    function automatic rv32i_types::commit_t expected_commit(input rv32i_types::ex_mem_t rec,
                                                             input logic [31:0] word);
        rv32i_types::commit_t c;
        logic [31:0] shifted;
        logic [15:0] half;
        logic [31:0] loaded;
        shifted = word >> (8 * rec.alu_out[1:0]);
        half = rec.alu_out[1] ? word[31:16] : word[15:0];
        case (rec.mem_signal.load_ops)
            rv32i_types::lb_mem:  loaded = 32'($signed(shifted[7:0]));
            rv32i_types::lbu_mem: loaded = {24'd0, shifted[7:0]};
            rv32i_types::lh_mem:  loaded = 32'($signed(half));
            rv32i_types::lhu_mem: loaded = {16'd0, half};
            default:              loaded = word;
        endcase
        c.valid = 1'b1;
        c.regf_we = rec.wb_signal.regf_we;
        c.rd_s = rec.rd_s;
        if (rec.mem_signal.mem_write || rec.inst[6:0] == rv32i_types::br_opcode) begin
            c.rd_s = 5'd0;
        end
        case (rec.wb_signal.regf_m_sel)
            rv32i_types::alu_out_wb:  c.rd_v = rec.alu_out;
            rv32i_types::br_en_wb:    c.rd_v = rec.br_en;
            rv32i_types::u_imm_wb:    c.rd_v = rec.u_imm;
            rv32i_types::pc_plus4_wb: c.rd_v = rec.pc + 32'd4;
            default:                  c.rd_v = loaded; // Any load select.
        endcase
        return c;
    endfunction

    function automatic rv32i_types::ex_mem_t base_record();
        rv32i_types::ex_mem_t rec;
        rec = '0;
        rec.valid = 1'b1;
        rec.inst = {25'($urandom()), 7'b0110011};
        rec.pc = $urandom() & 32'hffff_fffc;
        rec.alu_out = $urandom();
        rec.br_en = $urandom();
        rec.u_imm = $urandom();
        rec.rd_s = 5'($urandom());
        rec.wb_signal.regf_we = 1'b1;
        rec.wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
        rec.mem_signal.load_ops = rv32i_types::lw_mem;
        return rec;
    endfunction

    // Drives one record and returns once the DUT has taken it.
    task automatic issue(input rv32i_types::ex_mem_t rec);
        logic [7:0] idx;
        idx = rec.alu_out[9:2];
        @(posedge clk);
        ex_mem <= rec;
        fetch_en <= fetch_on;
        if (rec.valid) begin
            exp_q.push_back(expected_commit(rec, shadow_mem[idx]));
            if (rec.mem_signal.mem_write) begin
                shadow_mem[idx] = merge_bytes(shadow_mem[idx], rec.rs2_v, rec.mem_wmask);
            end
        end
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
    endtask

    task automatic bubble();
        issue('0);
    endtask

    task automatic store_word(input logic [7:0] idx, input logic full);
        rv32i_types::ex_mem_t rec;
        rec = base_record();
        rec.inst = {25'($urandom()), 7'b0100011};
        rec.mem_signal.mem_write = 1'b1;
        rec.alu_out = {22'd0, idx, 2'b00};
        rec.rs2_v = $urandom();
        rec.mem_wmask = full ? 4'hf : 4'($urandom());
        issue(rec);
    endtask

    task automatic load_lane(input logic [7:0] idx, input int kind, input logic [1:0] off);
        rv32i_types::ex_mem_t rec;
        rec = base_record();
        rec.inst = {25'($urandom()), 7'b0000011};
        rec.mem_signal.mem_read = 1'b1;
        case (kind)
            0: begin
                rec.mem_signal.load_ops = rv32i_types::lb_mem;
                rec.wb_signal.regf_m_sel = rv32i_types::lb_wb;
            end
            1: begin
                rec.mem_signal.load_ops = rv32i_types::lbu_mem;
                rec.wb_signal.regf_m_sel = rv32i_types::lbu_wb;
            end
            2: begin
                rec.mem_signal.load_ops = rv32i_types::lh_mem;
                rec.wb_signal.regf_m_sel = rv32i_types::lh_wb;
                off[0] = 1'b0;
            end
            3: begin
                rec.mem_signal.load_ops = rv32i_types::lhu_mem;
                rec.wb_signal.regf_m_sel = rv32i_types::lhu_wb;
                off[0] = 1'b0;
            end
            default: begin
                rec.wb_signal.regf_m_sel = rv32i_types::lw_wb;
                off = 2'd0;
            end
        endcase
        rec.alu_out = {22'd0, idx, off};
        issue(rec);
    endtask

    task automatic alu_op(input logic branch);
        rv32i_types::ex_mem_t rec;
        rec = base_record();
        if (branch) begin
            rec.inst[6:0] = rv32i_types::br_opcode;
            rec.wb_signal.regf_m_sel = rv32i_types::br_en_wb;
        end else begin
            case ($urandom() % 4)
                0: rec.wb_signal.regf_m_sel = rv32i_types::alu_out_wb;
                1: rec.wb_signal.regf_m_sel = rv32i_types::br_en_wb;
                2: rec.wb_signal.regf_m_sel = rv32i_types::u_imm_wb;
                default: rec.wb_signal.regf_m_sel = rv32i_types::pc_plus4_wb;
            endcase
        end
        issue(rec);
    endtask

    task automatic mix_step(input logic upper_only);
        logic [7:0] idx;
        idx = 8'($urandom());
        if (upper_only) begin
            idx[7] = 1'b1; // Fetch reads the lower half.
        end
        if ($urandom() % 4 == 0) begin
            bubble();
        end
        case ($urandom() % 4)
            0: begin
                store_word(idx, 1'b0);
                load_lane(idx, 4, 2'd0);
            end
            1: load_lane(8'($urandom()), int'($urandom() % 4), 2'($urandom()));
            2: alu_op(1'b0);
            default: alu_op(1'b1);
        endcase
    endtask

    always @(negedge clk) begin : compare_commits
        rv32i_types::commit_t head;
        if (checking) begin
            assert (rs1_v == shadow_regs[rs1_s])
                else fail_run($sformatf("Mismatch at %0t: x%0d reads %h, expected %h",
                                        $time, rs1_s, rs1_v, shadow_regs[rs1_s]));
            assert (rs2_v == shadow_regs[rs2_s])
                else fail_run($sformatf("Mismatch at %0t: x%0d reads %h, expected %h",
                                        $time, rs2_s, rs2_v, shadow_regs[rs2_s]));
            if (commit.valid) begin
                assert (exp_q.size() > 0)
                    else fail_run("A commit appeared with no record outstanding");
                head = exp_q.pop_front();
                assert (commit == head)
                    else fail_run($sformatf(
                        "Mismatch at %0t: commit rd %0d = %h we %b, expected rd %0d = %h we %b",
                        $time, commit.rd_s, commit.rd_v, commit.regf_we,
                        head.rd_s, head.rd_v, head.regf_we));
                if (head.regf_we && head.rd_s != 5'd0) begin
                    shadow_regs[head.rd_s] = head.rd_v;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (checking && fetch_valid) begin
            assert (fetch_pc == next_fetch_pc)
                else fail_run($sformatf("Mismatch at %0t: fetch pc %h, expected %h",
                                        $time, fetch_pc, next_fetch_pc));
            assert (fetch_inst == shadow_mem[fetch_pc[9:2]])
                else fail_run($sformatf("Mismatch at %0t: fetched %h at %h, expected %h",
                                        $time, fetch_inst, fetch_pc, shadow_mem[fetch_pc[9:2]]));
            next_fetch_pc = next_fetch_pc + 32'd4;
            fetch_count++;
        end
    end

    initial begin
        #(timeout_cycles * 4);
        fail_run("Timeout: the run did not finish in time");
    end

    initial begin
        rv32i_types::ex_mem_t zero_rec;
        void'($urandom(16944));
        rst = 1'b1;
        ex_mem = '0;
        fetch_en = 1'b0;
        fetch_start_pc = 32'd0;
        rs1_s = 5'd0;
        rs2_s = 5'd0;
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = 32'd0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!stall && !commit.valid && !fetch_valid)
            else fail_run("Stall, commit or fetch was active right after reset");
        checking = 1'b1;
        for (int i = 0; i < fill_records; i++) begin
            store_word(i[7:0], 1'b1);
        end
        for (int k = 0; k < 4; k++) begin
            for (int off = 0; off < 4; off++) begin
                load_lane(8'($urandom()), k, 2'(off));
            end
        end
        zero_rec = base_record();
        zero_rec.rd_s = 5'd0; // Write aimed at x0.
        issue(zero_rec);
        for (int i = 0; i < mix_records; i++) begin
            mix_step(1'b0);
        end
        fetch_on = 1'b1;
        for (int i = 0; i < fetch_records; i++) begin
            mix_step(1'b1);
        end
        fetch_on = 1'b0;
        bubble();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        assert (fetch_count > 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("No instruction word was fetched");
        end
    end

endmodule

// File: list.f
source/rv32i_types.sv
source/mem_bus_pkg.sv
source/mem_stage.sv
source/wb_stage.sv
source/regfile.sv
source/fetch_unit.sv
source/mem_arbiter.sv
source/unified_mem.sv
source/backend_top.sv
testbench/tb_backend.sv

// File: Makefile
TOP := tb_backend

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f list.f --top-module backend_top
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
